//--- rtl/lfsr_pkg.sv
// --------------------
// shared widths and constants for the link self-test
// polynomials drop the top term, as the LFSR core expects
// --------------------
package lfsr_pkg;

    // one link or host byte
    typedef logic [7:0] byte_t;

    // CRC32 running state and FCS
    typedef logic [31:0] crc_t;

    // PRBS31 shift register
    typedef logic [30:0] prbs_state_t;

    // bit error counter, saturates at all ones
    typedef logic [15:0] err_count_t;

    // Ethernet CRC32, reflected use with final inversion
    localparam crc_t crc32_poly = 32'h04c11db7;
    localparam crc_t crc32_init = 32'hffffffff;

    // x^31 + x^28 + 1
    localparam prbs_state_t prbs31_poly = 31'h10000001;
    // any nonzero value works, all ones is conventional
    localparam prbs_state_t prbs_seed = '1;

    // checker: filling the register, then counting errors
    typedef enum logic {
        chk_fill,
        chk_lock
    } chk_state_t;

endpackage

//--- rtl/lfsr.sv
// --------------------
// combinational parallel LFSR/CRC, data_width shifts per pass
// any lfsr_config other than "GALOIS" is built as Fibonacci
// tie data_in to zero for a plain pattern source
// masks are constants, so synthesis folds them into XOR trees
// --------------------
module lfsr #(
    parameter int lfsr_width = 31,
    parameter logic [lfsr_width-1:0] lfsr_poly = 31'h10000001,
    parameter lfsr_config = "FIBONACCI",
    parameter bit lfsr_feed_forward = 1'b0,
    parameter bit reverse = 1'b0,
    parameter int data_width = 8
) (
    input  logic [data_width-1:0] data_in,
    input  logic [lfsr_width-1:0] state_in,
    output logic [data_width-1:0] data_out,
    output logic [lfsr_width-1:0] state_out
);

    localparam bit is_galois = (lfsr_config == "GALOIS");

    // per next-state bit: which state bits and data bits feed it
    logic [lfsr_width-1:0] nxt_smask [lfsr_width];
    logic [data_width-1:0] nxt_dmask [lfsr_width];
    // per output bit: same, for the shifted-out stream
    logic [lfsr_width-1:0] out_smask [data_width];
    logic [data_width-1:0] out_dmask [data_width];

    // step the register symbolically, one data bit at a time
    always_comb begin
        logic [lfsr_width-1:0] fb_s;
        logic [data_width-1:0] fb_d;
        logic [lfsr_width-1:0] tmp_s;
        logic [data_width-1:0] tmp_d;

        // start from identity, each flop holds itself
        for (int i = 0; i < lfsr_width; i++) begin
            nxt_smask[i] = '0;
            nxt_smask[i][i] = 1'b1;
            nxt_dmask[i] = '0;
        end
        for (int i = 0; i < data_width; i++) begin
            out_smask[i] = '0;
            out_dmask[i] = '0;
        end

        // MSB of data goes in first
        for (int i = data_width - 1; i >= 0; i--) begin
            // last flop xor incoming data bit
            fb_s = nxt_smask[lfsr_width-1];
            fb_d = nxt_dmask[lfsr_width-1];
            fb_d[i] = ~fb_d[i];

            // fibonacci taps fold into the feedback term
            if (!is_galois) begin
                for (int j = 1; j < lfsr_width; j++) begin
                    if (lfsr_poly[j]) begin
                        fb_s = fb_s ^ nxt_smask[j-1];
                        fb_d = fb_d ^ nxt_dmask[j-1];
                    end
                end
            end

            // shift register and output history by one
            for (int j = lfsr_width - 1; j > 0; j--) begin
                nxt_smask[j] = nxt_smask[j-1];
                nxt_dmask[j] = nxt_dmask[j-1];
            end
            for (int j = data_width - 1; j > 0; j--) begin
                out_smask[j] = out_smask[j-1];
                out_dmask[j] = out_dmask[j-1];
            end
            out_smask[0] = fb_s;
            out_dmask[0] = fb_d;

            // feed-forward: register only ever sees raw input
            if (lfsr_feed_forward) begin
                fb_s = '0;
                fb_d = '0;
                fb_d[i] = 1'b1;
            end
            nxt_smask[0] = fb_s;
            nxt_dmask[0] = fb_d;

            // galois taps xor the feedback into the chain
            if (is_galois) begin
                for (int j = 1; j < lfsr_width; j++) begin
                    if (lfsr_poly[j]) begin
                        nxt_smask[j] = nxt_smask[j] ^ fb_s;
                        nxt_dmask[j] = nxt_dmask[j] ^ fb_d;
                    end
                end
            end
        end

        // LSB-first mode: mirror bit order on every port
        if (reverse) begin
            for (int i = 0; i < lfsr_width / 2; i++) begin
                tmp_s = nxt_smask[i];
                tmp_d = nxt_dmask[i];
                nxt_smask[i] = nxt_smask[lfsr_width-1-i];
                nxt_dmask[i] = nxt_dmask[lfsr_width-1-i];
                nxt_smask[lfsr_width-1-i] = tmp_s;
                nxt_dmask[lfsr_width-1-i] = tmp_d;
            end
            for (int i = 0; i < data_width / 2; i++) begin
                tmp_s = out_smask[i];
                tmp_d = out_dmask[i];
                out_smask[i] = out_smask[data_width-1-i];
                out_dmask[i] = out_dmask[data_width-1-i];
                out_smask[data_width-1-i] = tmp_s;
                out_dmask[data_width-1-i] = tmp_d;
            end
            // and mirror the select masks themselves
            for (int i = 0; i < lfsr_width; i++) begin
                nxt_smask[i] = {<<{nxt_smask[i]}};
                nxt_dmask[i] = {<<{nxt_dmask[i]}};
            end
            for (int i = 0; i < data_width; i++) begin
                out_smask[i] = {<<{out_smask[i]}};
                out_dmask[i] = {<<{out_dmask[i]}};
            end
        end
    end

    // each output bit is the parity of its selected inputs
    for (genvar n = 0; n < lfsr_width; n++) begin : g_state
        assign state_out[n] = ^{state_in & nxt_smask[n], data_in & nxt_dmask[n]};
    end
    for (genvar n = 0; n < data_width; n++) begin : g_data
        assign data_out[n] = ^{state_in & out_smask[n], data_in & out_dmask[n]};
    end

endmodule

//--- rtl/prbs_gen.sv
// --------------------
// PRBS31 source, MSB first, data_width bits per enabled cycle
// output is registered, one cycle behind gen_en
// --------------------
module prbs_gen #(
    parameter int data_width = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  gen_en,
    output logic [data_width-1:0] tx_data,
    output logic                  tx_valid
);

    import lfsr_pkg::*;

    prbs_state_t           prbs_state;
    prbs_state_t           state_next;
    logic [data_width-1:0] data_next;

    // no data input, pure pattern generation
    lfsr #(
        .lfsr_width       ($bits(prbs_state_t)),
        .lfsr_poly        (prbs31_poly),
        .lfsr_config      ("FIBONACCI"),
        .lfsr_feed_forward(1'b0),
        .reverse          (1'b0),
        .data_width       (data_width)
    ) i_lfsr (
        .data_in  ({data_width{1'b0}}),
        .state_in (prbs_state),
        .data_out (data_next),
        .state_out(state_next)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            prbs_state <= prbs_seed;
            tx_valid   <= 1'b0;
        end else begin
            // stall holds the pattern position
            if (gen_en) begin
                prbs_state <= state_next;
            end
            tx_valid <= gen_en;
        end
    end

    // payload only, qualified by tx_valid
    always_ff @(posedge clk) begin
        if (gen_en) begin
            tx_data <= data_next;
        end
    end

endmodule

//--- rtl/prbs_check.sv
// --------------------
// self-synchronizing PRBS31 checker
// first fill_beats valid beats load the register, then lock
// lock holds until reset, fill_beats must be at least 1
// one flipped line bit shows up as three errors
// --------------------
module prbs_check #(
    parameter int data_width = 8,
    parameter int fill_beats = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [data_width-1:0] rx_data,
    input  logic                  rx_valid,
    output lfsr_pkg::err_count_t  err_count,
    output logic                  locked
);

    import lfsr_pkg::*;

    localparam int cnt_w = (fill_beats > 1) ? $clog2(fill_beats) : 1;

    chk_state_t                  chk_state;
    logic [cnt_w-1:0]            fill_cnt;
    prbs_state_t                 prbs_state;
    prbs_state_t                 state_next;
    logic [data_width-1:0]       err_bits;
    err_count_t                  bit_errs;
    logic [$bits(err_count_t):0] err_sum;

    function automatic err_count_t count_ones(logic [data_width-1:0] v);
        err_count_t cnt;
        cnt = '0;
        for (int i = 0; i < data_width; i++) begin
            cnt = cnt + err_count_t'(v[i]);
        end
        return cnt;
    endfunction

    // feed-forward: state is just the last 31 received bits
    lfsr #(
        .lfsr_width       ($bits(prbs_state_t)),
        .lfsr_poly        (prbs31_poly),
        .lfsr_config      ("FIBONACCI"),
        .lfsr_feed_forward(1'b1),
        .reverse          (1'b0),
        .data_width       (data_width)
    ) i_lfsr (
        .data_in  (rx_data),
        .state_in (prbs_state),
        .data_out (err_bits),
        .state_out(state_next)
    );

    // any 1 left after descrambling is a mismatch
    assign bit_errs = count_ones(err_bits);
    assign err_sum  = {1'b0, err_count} + {1'b0, bit_errs};
    assign locked   = (chk_state == chk_lock);

    always_ff @(posedge clk) begin
        if (rx_valid) begin
            prbs_state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            chk_state <= chk_fill;
            fill_cnt  <= '0;
            err_count <= '0;
        end else if (rx_valid) begin
            case (chk_state)
                chk_fill: begin
                    fill_cnt <= fill_cnt + 1'b1;
                    if (fill_cnt == cnt_w'(fill_beats - 1)) begin
                        chk_state <= chk_lock;
                    end
                end
                chk_lock: begin
                    // saturate rather than wrap
                    if (err_sum[$bits(err_count_t)]) begin
                        err_count <= '1;
                    end else begin
                        err_count <= err_sum[$bits(err_count_t)-1:0];
                    end
                end
            endcase
        end
    end

endmodule

//--- rtl/crc32_frame.sv
// --------------------
// Ethernet-style CRC32 over host bytes, LSB first per byte
// fcs is the inverted final state, held until the next frame ends
// host_start and host_last only count together with host_valid
// --------------------
module crc32_frame (
    input  logic            clk,
    input  logic            rst,
    input  lfsr_pkg::byte_t host_data,
    input  logic            host_valid,
    input  logic            host_start,
    input  logic            host_last,
    output lfsr_pkg::crc_t  fcs,
    output logic            fcs_done
);

    import lfsr_pkg::*;

    crc_t crc_state;
    crc_t crc_in;
    crc_t crc_next;

    // first byte of a frame starts from the init value
    assign crc_in = host_start ? crc32_init : crc_state;

    // reflected galois form, data_out not needed for CRC
    lfsr #(
        .lfsr_width       ($bits(crc_t)),
        .lfsr_poly        (crc32_poly),
        .lfsr_config      ("GALOIS"),
        .lfsr_feed_forward(1'b0),
        .reverse          (1'b1),
        .data_width       ($bits(byte_t))
    ) i_lfsr (
        .data_in  (host_data),
        .state_in (crc_in),
        .data_out (),
        .state_out(crc_next)
    );

    always_ff @(posedge clk) begin
        if (host_valid) begin
            crc_state <= crc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fcs      <= '0;
            fcs_done <= 1'b0;
        end else begin
            // one-cycle pulse after the last byte
            fcs_done <= host_valid && host_last;
            if (host_valid && host_last) begin
                fcs <= ~crc_next;
            end
        end
    end

endmodule

//--- rtl/link_test_top.sv
// --------------------
// link self-test: PRBS loopback with error mask, plus CRC32
// the three blocks run independently on one clock
// --------------------
module link_test_top #(
    parameter int fill_beats = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 gen_en,
    input  lfsr_pkg::byte_t      inject_mask,
    input  lfsr_pkg::byte_t      host_data,
    input  logic                 host_valid,
    input  logic                 host_start,
    input  logic                 host_last,
    output lfsr_pkg::byte_t      tx_data,
    output logic                 tx_valid,
    output lfsr_pkg::err_count_t err_count,
    output logic                 locked,
    output lfsr_pkg::crc_t       fcs,
    output logic                 fcs_done
);

    import lfsr_pkg::*;

    localparam int lane_width = $bits(byte_t);

    byte_t rx_data;
    logic  rx_valid;

    prbs_gen #(
        .data_width(lane_width)
    ) i_prbs_gen (
        .clk     (clk),
        .rst     (rst),
        .gen_en  (gen_en),
        .tx_data (tx_data),
        .tx_valid(tx_valid)
    );

    // loopback, mask flips bits in the same cycle
    assign rx_data  = tx_data ^ inject_mask;
    assign rx_valid = tx_valid;

    prbs_check #(
        .data_width(lane_width),
        .fill_beats(fill_beats)
    ) i_prbs_check (
        .clk      (clk),
        .rst      (rst),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .err_count(err_count),
        .locked   (locked)
    );

    crc32_frame i_crc32_frame (
        .clk       (clk),
        .rst       (rst),
        .host_data (host_data),
        .host_valid(host_valid),
        .host_start(host_start),
        .host_last (host_last),
        .fcs       (fcs),
        .fcs_done  (fcs_done)
    );

endmodule

//--- bench/link_test_tb.sv
// --------------------
// testbench for link_test_top driven from bench/link_test_input.txt
// consecutive crc lines are sent back to back
// PRBS injections need four clean beats after them
// --------------------
module link_test_tb;

    import lfsr_pkg::*;

    localparam int fill_beats = 4;

    logic       clk = 1'b0;
    logic       rst;
    logic       gen_en;
    byte_t      inject_mask;
    byte_t      host_data;
    logic       host_valid;
    logic       host_start;
    logic       host_last;
    byte_t      tx_data;
    logic       tx_valid;
    err_count_t err_count;
    logic       locked;
    crc_t       fcs;
    logic       fcs_done;

    // bench bookkeeping
    int          cyc = 0;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    bit          run_checks = 1'b0;
    bit          timed_out = 1'b0;
    logic [31:0] rng = 32'he7dc_30ed;
    prbs_state_t model_state = prbs_seed;
    int          total_beats = 0;
    int          exp_err = 0;
    int          frames_sent = 0;
    int          frames_done = 0;
    byte_t       frame_buf [64];
    crc_t        exp_fcs_q [$];
    int          done_cyc_q [$];

    link_test_top #(
        .fill_beats(fill_beats)
    ) i_dut (
        .clk        (clk),
        .rst        (rst),
        .gen_en     (gen_en),
        .inject_mask(inject_mask),
        .host_data  (host_data),
        .host_valid (host_valid),
        .host_start (host_start),
        .host_last  (host_last),
        .tx_data    (tx_data),
        .tx_valid   (tx_valid),
        .err_count  (err_count),
        .locked     (locked),
        .fcs        (fcs),
        .fcs_done   (fcs_done)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string msg);
        if (got !== exp) begin
            $display("** Error at time %0t: %s, got %h, expected %h", $time, msg, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input bit ok);
        tests_run++;
        if (ok) begin
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: fail", name);
        end
    endtask

    // software PRBS31 x^31 + x^28 + 1 with the byte MSB going out first
    task automatic prbs_model_byte(output byte_t b);
        logic nb;
        b = '0;
        for (int k = 0; k < 8; k++) begin
            nb = model_state[30] ^ model_state[27];
            model_state = {model_state[29:0], nb};
            b = {b[6:0], nb};
        end
    endtask

    // tx stream against the model and lock level every cycle
    always @(negedge clk) begin : prbs_monitor
        byte_t exp_byte;
        if (run_checks) begin
            check_value(locked, total_beats >= fill_beats, "locked level");
            if (tx_valid === 1'b1) begin
                prbs_model_byte(exp_byte);
                check_value(tx_data, exp_byte, "tx_data vs PRBS31 model");
                total_beats++;
            end
        end
    end

    // done pulses pair up with the frames in send order
    always @(negedge clk) begin : crc_monitor
        int errs_before;
        if (run_checks && fcs_done === 1'b1) begin
            errs_before = errors;
            if (exp_fcs_q.size() == 0) begin
                $display("fcs_done pulsed at time %0t with no frame pending", $time);
                errors++;
            end else begin
                check_value(fcs, exp_fcs_q.pop_front(), "fcs value");
                check_value(cyc, done_cyc_q.pop_front(), "fcs_done cycle");
                frames_done++;
                report_test($sformatf("crc frame %0d", frames_done), errors == errs_before);
            end
        end
    end

    // bytes from frame_buf with random idle cycles only inside the frame
    task automatic send_frame(input int n);
        int gaps;
        for (int i = 0; i < n; i++) begin
            rng = xorshift32(rng);
            gaps = (i == 0) ? 0 : int'(rng[1:0]);
            repeat (gaps) begin
                @(negedge clk);
                host_valid = 1'b0;
                host_start = 1'b0;
                host_last  = 1'b0;
            end
            @(negedge clk);
            host_data  = frame_buf[i];
            host_valid = 1'b1;
            host_start = (i == 0);
            host_last  = (i == n - 1);
            if (i == n - 1) begin
                done_cyc_q.push_back(cyc + 1);
            end
        end
    endtask

    // idle the host side and wait for every pending done
    task automatic drain_crc();
        int waited;
        waited = 0;
        @(negedge clk);
        host_valid = 1'b0;
        host_start = 1'b0;
        host_last  = 1'b0;
        while (frames_done < frames_sent && !timed_out) begin
            @(negedge clk);
            waited++;
            if (waited > 50) begin
                $display("timeout: CRC frames never finished, %0d of %0d done",
                         frames_done, frames_sent);
                timed_out = 1'b1;
            end
        end
    endtask

    // one PRBS run with random gen_en gaps and the mask on one chosen beat
    task automatic run_prbs(input int beats, input int inj_beat, input byte_t mask,
                            input int run_no);
        int issued;
        int seen;
        int waited;
        int errs_before;
        int ones;
        issued = 0;
        seen = 0;
        waited = 0;
        ones = 0;
        errs_before = errors;
        while (seen < beats && !timed_out) begin
            @(negedge clk);
            inject_mask = 8'h00;
            if (tx_valid === 1'b1) begin
                seen++;
                if (seen == inj_beat) begin
                    inject_mask = mask;
                end
            end
            rng = xorshift32(rng);
            if (issued < beats && rng[1:0] != 2'b00) begin
                gen_en = 1'b1;
                issued++;
            end else begin
                gen_en = 1'b0;
            end
            waited++;
            if (waited > beats * 4 + 20) begin
                $display("timeout: PRBS run %0d saw only %0d of %0d beats",
                         run_no, seen, beats);
                timed_out = 1'b1;
            end
        end
        // each flipped bit hits itself and both taps
        if (inj_beat > 0) begin
            for (int k = 0; k < 8; k++) begin
                ones = ones + int'(mask[k]);
            end
        end
        exp_err = exp_err + 3 * ones;
        // counter settles one cycle after the last beat
        @(negedge clk);
        inject_mask = 8'h00;
        check_value(err_count, exp_err, "err_count after PRBS run");
        report_test($sformatf("prbs run %0d, mask %h", run_no, mask), errors == errs_before);
    endtask

    initial begin : main
        int          fd;
        int          n;
        int          beats;
        int          inj;
        int          runs;
        int          errs_before;
        logic [31:0] val;
        crc_t        exp;
        logic [63:0] tok;
        logic [1023:0] line_buf;

        runs = 0;
        rst = 1'b1;
        // strobes held high through reset so only reset keeps outputs low
        gen_en = 1'b1;
        inject_mask = 8'h00;
        host_data = 8'h00;
        host_valid = 1'b1;
        host_start = 1'b0;
        host_last = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        gen_en = 1'b0;
        host_valid = 1'b0;
        host_last = 1'b0;

        errs_before = errors;
        check_value(tx_valid, 0, "tx_valid after reset");
        check_value(locked, 0, "locked after reset");
        check_value(fcs_done, 0, "fcs_done after reset");
        check_value(err_count, 0, "err_count after reset");
        check_value(fcs, 0, "fcs after reset");
        report_test("reset state", errors == errs_before);
        run_checks = 1'b1;

        fd = $fopen("bench/link_test_input.txt", "r");
        if (fd == 0) begin
            $display("could not open bench/link_test_input.txt");
            errors++;
        end else begin
            while (!timed_out && $fscanf(fd, "%s", tok) == 1) begin
                if (tok == "#") begin
                    n = $fgets(line_buf, fd);
                end else if (tok == "crc") begin
                    n = $fscanf(fd, "%d", beats);
                    for (int i = 0; i < beats; i++) begin
                        n = $fscanf(fd, "%h", val);
                        frame_buf[i] = val[7:0];
                    end
                    n = $fscanf(fd, "%h", exp);
                    exp_fcs_q.push_back(exp);
                    frames_sent++;
                    send_frame(beats);
                end else if (tok == "prbs") begin
                    n = $fscanf(fd, "%d %d %h", beats, inj, val);
                    drain_crc();
                    runs++;
                    run_prbs(beats, inj, val[7:0], runs);
                end else begin
                    $display("input file has an unknown line type: %0s", tok);
                    errors++;
                end
            end
            $fclose(fd);
            drain_crc();
        end

        $display("%0d tests, %0d failed, %0d check errors", tests_run, tests_failed, errors);
        if (errors == 0 && !timed_out) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- bench/link_test_input.txt
# crc  <byte count> <bytes in hex> <expected fcs in hex>
# prbs <beats> <beat to inject on, 0 for none> <inject mask in hex>
prbs 200 0 00
crc 9 31 32 33 34 35 36 37 38 39 cbf43926
crc 1 00 d202ef8d
crc 1 61 e8b7be43
crc 3 61 62 63 352441c2
crc 4 00 00 00 00 2144df1c
crc 4 ff ff ff ff ffffffff
crc 11 68 65 6c 6c 6f 20 77 6f 72 6c 64 0d4a1185
prbs 40 10 01
prbs 40 7 80
prbs 60 20 81
prbs 30 5 05
prbs 50 12 a3
crc 3 61 62 63 352441c2
crc 1 00 d202ef8d

//--- sources.f
rtl/lfsr_pkg.sv
rtl/lfsr.sv
rtl/prbs_gen.sv
rtl/prbs_check.sv
rtl/crc32_frame.sv
rtl/link_test_top.sv
bench/link_test_tb.sv
